// File: design/neuronPool_macros.svh
`ifndef NEURON_POOL_MACROS_SVH
`define NEURON_POOL_MACROS_SVH

// pool size and field widths
`define NEURON_COUNT  16
`define INDEX_W       4
`define FIX_W         18
`define STEP_W        16

// euler step and izhikevich a, b as shifts
`define DT_SHIFT      4
`define A_SHIFT       3
`define B_SHIFT       2

// q2.16 constants
`define V_RESET       18'sh3599A
`define U_BUMP        18'sh0147A
`define V_PEAK        18'sh04CCC
`define V_REST        18'sh34CCD
`define REST_BIAS     18'sh16666
`define SYN_WEIGHT    18'sh01000
`define SYN_TAU_SHIFT 2
`define SIZE_STEP     18'sh00100

// output side
`define QUEUE_DEPTH   8
`define CREDIT_INIT   4

`endif

// File: design/neuronPoolPkg.sv
`include "neuronPool_macros.svh"

package neuronPoolPkg;

    ////////////////////////////////////////////////////////////////////
    // value types
    ////////////////////////////////////////////////////////////////////

    // q2.16 signed, range -2 .. +2
    typedef logic signed [`FIX_W-1:0] fixT;

    // cell address within one array
    typedef logic [`INDEX_W-1:0] cellIdxT;

    // simulation step number, wraps
    typedef logic [`STEP_W-1:0] stepT;

    // one motoneuron spike as it leaves the pool
    // step in the upper bits, cell index below
    typedef struct packed {
        stepT    step;
        cellIdxT index;
    } spikeEventT;

    ////////////////////////////////////////////////////////////////////
    // scan schedule
    ////////////////////////////////////////////////////////////////////

    // four ticks per cell
    typedef enum logic [1:0] {
        phRead    = 2'd0,
        phCompute = 2'd1,
        phWrite   = 2'd2,
        phSettle  = 2'd3
    } phaseT;

endpackage

// File: design/neuronLinkIf.sv
// scan schedule shared by all compute units
interface neuronLinkIf;
    import neuronPoolPkg::*;

    // cell currently being processed
    cellIdxT cellIdx;
    // phase of that cell
    phaseT   phase;
    // one-cycle enable, units act only here
    logic    tick;
    // step the scan belongs to
    stepT    step;

    // sequencer side
    modport sched (
        output cellIdx, phase, tick, step
    );

    // neuron and synapse arrays
    modport unit (
        input cellIdx, phase, tick, step
    );

endinterface

// File: design/neuronSequencer.sv
`include "neuronPool_macros.svh"

module neuronSequencer (
    input  logic                   rawclk,
    input  logic                   rstN,
    input  logic [15:0]            halfCnt,
    input  logic                   runEn,
    input  logic                   stall,
    neuronLinkIf.sched             link,
    output logic                   clearActive,
    output neuronPoolPkg::cellIdxT clearIdx
);
    import neuronPoolPkg::*;

    logic [15:0] tickCnt;
    cellIdxT     idxReg;
    phaseT       phaseReg;
    stepT        stepReg;
    logic        hold;
    logic        tickNow;
    logic        lastCell;

    ////////////////////////////////////////////////////////////////////
    // tick generation
    ////////////////////////////////////////////////////////////////////

    // no ticks while clearing, disabled, or queue has no room
    // stall only looked at before a cell starts
    assign hold     = !runEn || clearActive || (phaseReg == phRead && stall);
    assign tickNow  = !hold && (tickCnt == halfCnt);
    assign lastCell = (idxReg == cellIdxT'(`NEURON_COUNT - 1));

    // one tick every halfCnt+1 cycles
    always_ff @(posedge rawclk) begin
        if (!rstN || hold || tickNow) begin
            tickCnt <= '0;
        end else begin
            tickCnt <= tickCnt + 16'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // clear scan, one memory entry per cycle after reset
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            clearActive <= 1'b1;
            clearIdx    <= '0;
        end else if (clearActive) begin
            clearIdx <= clearIdx + cellIdxT'(1);
            if (clearIdx == cellIdxT'(`NEURON_COUNT - 1)) begin
                clearActive <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // phase, cell and step walk
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            phaseReg <= phRead;
            idxReg   <= '0;
            stepReg  <= '0;
        end else if (tickNow) begin
            phaseReg <= phaseT'(phaseReg + 2'd1);
            if (phaseReg == phSettle) begin
                // next cell, wrap ends the step
                if (lastCell) begin
                    idxReg  <= '0;
                    stepReg <= stepReg + stepT'(1);
                end else begin
                    idxReg <= idxReg + cellIdxT'(1);
                end
            end
        end
    end

    assign link.tick    = tickNow;
    assign link.phase   = phaseReg;
    assign link.cellIdx = idxReg;
    assign link.step    = stepReg;

endmodule

// File: design/izhNeuronArray.sv
`include "neuronPool_macros.svh"

module izhNeuronArray (
    input  logic                   rawclk,
    input  logic                   rstN,
    neuronLinkIf.unit              link,
    input  logic                   clearActive,
    input  neuronPoolPkg::cellIdxT clearIdx,
    input  neuronPoolPkg::fixT     current,
    output logic                   spike
);
    import neuronPoolPkg::*;

    // headroom for 4*vsq and the sum of terms
    localparam int WIDE_W = 24;

    // per-cell state
    fixT vMem [`NEURON_COUNT];
    fixT uMem [`NEURON_COUNT];

    // state of the cell being worked on
    fixT vCur;
    fixT uCur;
    // registered update
    fixT vNew;
    fixT uNew;
    logic spikeNew;

    logic signed [35:0]       prodVV;
    logic signed [WIDE_W-1:0] vsq;
    logic signed [WIDE_W-1:0] vWide;
    logic signed [WIDE_W-1:0] uWide;
    logic signed [WIDE_W-1:0] curWide;
    logic signed [WIDE_W-1:0] dv;
    logic signed [WIDE_W-1:0] du;
    logic signed [WIDE_W-1:0] vSum;
    logic signed [WIDE_W-1:0] uSum;
    logic signed [WIDE_W-1:0] uBumped;
    logic fire;

    logic readTick;
    logic computeTick;
    logic writeTick;

    assign readTick    = link.tick && (link.phase == phRead);
    assign computeTick = link.tick && (link.phase == phCompute);
    assign writeTick   = link.tick && (link.phase == phWrite);

    ////////////////////////////////////////////////////////////////////
    // izhikevich update
    ////////////////////////////////////////////////////////////////////

    // sign extend into the wide domain
    assign vWide   = vCur;
    assign uWide   = uCur;
    assign curWide = current;

    // v squared back in q2.16
    assign prodVV = vCur * vCur;
    assign vsq    = $signed(prodVV[35:16]);

    // 4 vsq + 5 v + 1.4 - u + I
    assign dv = (vsq <<< 2) + (vWide <<< 2) + vWide + `REST_BIAS - uWide + curWide;
    assign vSum = vWide + (dv >>> `DT_SHIFT);

    // a (b v - u), scaled by dt
    assign du   = (vWide >>> `B_SHIFT) - uWide;
    assign uSum = uWide + (du >>> (`A_SHIFT + `DT_SHIFT));

    // threshold on the untruncated value
    assign fire    = (vSum >= `V_PEAK);
    // recovery bump applied after the regular u step
    assign uBumped = uSum + `U_BUMP;

    ////////////////////////////////////////////////////////////////////
    // state memories and pipeline
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge rawclk) begin
        if (clearActive) begin
            // resting state
            vMem[clearIdx] <= `V_REST;
            uMem[clearIdx] <= fixT'(`V_REST >>> `B_SHIFT);
        end else if (writeTick) begin
            vMem[link.cellIdx] <= vNew;
            uMem[link.cellIdx] <= uNew;
        end
        if (readTick) begin
            vCur <= vMem[link.cellIdx];
            uCur <= uMem[link.cellIdx];
        end
        if (computeTick) begin
            vNew <= fire ? `V_RESET : vSum[`FIX_W-1:0];
            uNew <= fire ? uBumped[`FIX_W-1:0] : uSum[`FIX_W-1:0];
        end
    end

    // spike flag of the pending write
    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            spikeNew <= 1'b0;
        end else if (computeTick) begin
            spikeNew <= fire;
        end
    end

    // strobe for exactly the write tick
    assign spike = writeTick && spikeNew;

endmodule

// File: design/decaySynapseArray.sv
`include "neuronPool_macros.svh"

module decaySynapseArray (
    input  logic                   rawclk,
    input  logic                   rstN,
    neuronLinkIf.unit              link,
    input  logic                   clearActive,
    input  neuronPoolPkg::cellIdxT clearIdx,
    input  logic                   preSpike,
    output neuronPoolPkg::fixT     synCurrent
);
    import neuronPoolPkg::*;

    // per-cell synaptic current
    fixT iMem [`NEURON_COUNT];

    // presynaptic spike seen at write
    logic preLatch;
    fixT  decayed;
    fixT  charged;

    logic readTick;
    logic writeTick;
    logic settleTick;

    assign readTick   = link.tick && (link.phase == phRead);
    assign writeTick  = link.tick && (link.phase == phWrite);
    assign settleTick = link.tick && (link.phase == phSettle);

    ////////////////////////////////////////////////////////////////////
    // decay and charge
    ////////////////////////////////////////////////////////////////////

    // I - I/4
    assign decayed = synCurrent - (synCurrent >>> `SYN_TAU_SHIFT);
    // add one weight per Ia spike
    assign charged = preLatch ? decayed + `SYN_WEIGHT : decayed;

    ////////////////////////////////////////////////////////////////////
    // memory
    ////////////////////////////////////////////////////////////////////

    // stored value drives the motoneuron from read on,
    // settle result only shows next step
    always_ff @(posedge rawclk) begin
        if (clearActive) begin
            iMem[clearIdx] <= '0;
        end else if (settleTick) begin
            iMem[link.cellIdx] <= charged;
        end
        if (readTick) begin
            synCurrent <= iMem[link.cellIdx];
        end
    end

    // Ia strobe only lasts the write tick
    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            preLatch <= 1'b0;
        end else if (writeTick) begin
            preLatch <= preSpike;
        end
    end

endmodule

// File: design/spikeEventQueue.sv
`include "neuronPool_macros.svh"

module spikeEventQueue (
    input  logic                      rawclk,
    input  logic                      rstN,
    input  logic                      push,
    input  neuronPoolPkg::spikeEventT spikeEvent,
    output logic                      stall,
    output logic                      spikeValid,
    output neuronPoolPkg::stepT       spikeStep,
    output neuronPoolPkg::cellIdxT    spikeIndex,
    input  logic                      creditReturn
);
    import neuronPoolPkg::*;

    localparam int PTR_W  = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W  = $clog2(`QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(`CREDIT_INIT + 1);

    spikeEventT qMem [`QUEUE_DEPTH];

    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic pop;

    // send when something is held and the receiver has a slot
    assign pop = (count != '0) && (credits != '0);

    // full queue holds the scan before the next cell,
    // at most one event per cell so this never overflows
    assign stall = (count == CNT_W'(`QUEUE_DEPTH));

    ////////////////////////////////////////////////////////////////////
    // buffer and output word
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge rawclk) begin
        if (push) begin
            qMem[wrPtr] <= spikeEvent;
        end
        if (pop) begin
            spikeStep  <= qMem[rdPtr].step;
            spikeIndex <= qMem[rdPtr].index;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // pointers, fill level, credits
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            credits    <= CRED_W'(`CREDIT_INIT);
            spikeValid <= 1'b0;
        end else begin
            spikeValid <= pop;
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // fill level
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit per valid, one back per return
            case ({pop, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: design/neuronPool.sv
`include "neuronPool_macros.svh"

module neuronPool (
    input  logic                   rawclk,
    input  logic                   rstN,
    input  logic                   runEn,
    input  logic [15:0]            halfCnt,
    input  neuronPoolPkg::fixT     rateIa,
    input  neuronPoolPkg::fixT     ppsCoef,
    input  neuronPoolPkg::fixT     gainMn,
    output logic                   spikeValid,
    output neuronPoolPkg::stepT    spikeStep,
    output neuronPoolPkg::cellIdxT spikeIndex,
    input  logic                   creditReturn
);
    import neuronPoolPkg::*;

    neuronLinkIf link ();

    logic    clearActive;
    cellIdxT clearIdx;
    logic    stall;

    // Ia side
    logic signed [35:0] iaProd;
    fixT                iaCurrent;
    logic               iaSpike;

    // synapse to motoneuron
    fixT                synCurrent;
    logic signed [35:0] mnProd;
    fixT                sizeOffset;
    fixT                mnCurrent;
    logic               mnSpike;
    spikeEventT         mnEvent;

    ////////////////////////////////////////////////////////////////////
    // drive arithmetic
    ////////////////////////////////////////////////////////////////////

    // firing rate times spindle coefficient, same for every Ia cell
    assign iaProd    = rateIa * ppsCoef;
    assign iaCurrent = fixT'(iaProd >>> 16);

    // size principle, higher index needs more drive
    assign sizeOffset = fixT'(link.cellIdx) * `SIZE_STEP;

    // synaptic current times gain, less the offset
    assign mnProd    = synCurrent * gainMn;
    assign mnCurrent = fixT'(mnProd >>> 16) - sizeOffset;

    ////////////////////////////////////////////////////////////////////
    // schedule
    ////////////////////////////////////////////////////////////////////

    neuronSequencer sequencer (
        .rawclk      (rawclk),
        .rstN        (rstN),
        .halfCnt     (halfCnt),
        .runEn       (runEn),
        .stall       (stall),
        .link        (link.sched),
        .clearActive (clearActive),
        .clearIdx    (clearIdx)
    );

    ////////////////////////////////////////////////////////////////////
    // neuron arrays and synapse
    ////////////////////////////////////////////////////////////////////

    izhNeuronArray iaArray (
        .rawclk      (rawclk),
        .rstN        (rstN),
        .link        (link.unit),
        .clearActive (clearActive),
        .clearIdx    (clearIdx),
        .current     (iaCurrent),
        .spike       (iaSpike)
    );

    decaySynapseArray synapse (
        .rawclk      (rawclk),
        .rstN        (rstN),
        .link        (link.unit),
        .clearActive (clearActive),
        .clearIdx    (clearIdx),
        .preSpike    (iaSpike),
        .synCurrent  (synCurrent)
    );

    izhNeuronArray mnArray (
        .rawclk      (rawclk),
        .rstN        (rstN),
        .link        (link.unit),
        .clearActive (clearActive),
        .clearIdx    (clearIdx),
        .current     (mnCurrent),
        .spike       (mnSpike)
    );

    ////////////////////////////////////////////////////////////////////
    // output events
    ////////////////////////////////////////////////////////////////////

    // tag with step and cell of the write tick
    assign mnEvent.step  = link.step;
    assign mnEvent.index = link.cellIdx;

    spikeEventQueue eventQueue (
        .rawclk       (rawclk),
        .rstN         (rstN),
        .push         (mnSpike),
        .spikeEvent   (mnEvent),
        .stall        (stall),
        .spikeValid   (spikeValid),
        .spikeStep    (spikeStep),
        .spikeIndex   (spikeIndex),
        .creditReturn (creditReturn)
    );

endmodule

// File: bench/neuronPoolTb.sv
`include "neuronPool_macros.svh"

module neuronPoolTb;
    timeunit 1ns;
    timeprecision 1ps;

    import neuronPoolPkg::*;

    // stimulus levels in q2.16
    localparam fixT RATE_IA   = 18'sh18000;
    localparam fixT PPS_UNIT  = 18'sh10000;
    localparam fixT GAIN_HIGH = 18'sh1E666;
    localparam fixT GAIN_MOD  = 18'sh10000;

    localparam int RUN_STEPS  = 300;
    localparam int PART_STEPS = 120;
    // five full runs at halfCnt 0, one at halfCnt 3, one partial run
    localparam int CYCLE_LIMIT =
        2 * `NEURON_COUNT * 4 * (5 * RUN_STEPS + 4 * RUN_STEPS + PART_STEPS) + 1000;

    logic        rawclk;
    logic        rstN;
    logic        runEn;
    logic [15:0] halfCnt;
    fixT         rateIa;
    fixT         ppsCoef;
    fixT         gainMn;
    logic        spikeValid;
    stepT        spikeStep;
    cellIdxT     spikeIndex;
    logic        creditReturn = 1'b0;

    // expected events, front is next
    stepT    expSteps[$];
    cellIdxT expIdx[$];

    string  testName = "idle";
    bit     checking = 1'b0;
    bit     backPressure = 1'b0;
    integer seed = 16;
    int     cycleCount = 0;

    // credit bookkeeping
    int issued;
    int returned;
    int owed;
    int returnDelay;
    bit returnNext = 1'b0;

    neuronPool uut (
        .rawclk       (rawclk),
        .rstN         (rstN),
        .runEn        (runEn),
        .halfCnt      (halfCnt),
        .rateIa       (rateIa),
        .ppsCoef      (ppsCoef),
        .gainMn       (gainMn),
        .spikeValid   (spikeValid),
        .spikeStep    (spikeStep),
        .spikeIndex   (spikeIndex),
        .creditReturn (creditReturn)
    );

    initial begin
        rawclk = 1'b0;
        forever #5 rawclk = ~rawclk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // truncate to 18 bits, keep the sign of bit 17
    function automatic int wrapFix(input longint x);
        fixT t;
        t = fixT'(x);
        return int'(t);
    endfunction

    // one euler step of one cell
    function automatic void izhStep(inout int v, inout int u, input int cur, output bit fired);
        int vsq;
        int dv;
        int du;
        int vSum;
        int uSum;
        vsq  = int'((longint'(v) * longint'(v)) >>> 16);
        dv   = 4 * vsq + 5 * v + `REST_BIAS - u + cur;
        vSum = v + (dv >>> `DT_SHIFT);
        du   = (v >>> `B_SHIFT) - u;
        uSum = u + (du >>> (`A_SHIFT + `DT_SHIFT));
        fired = (vSum >= `V_PEAK);
        if (fired) begin
            v = `V_RESET;
            u = wrapFix(uSum + `U_BUMP);
        end else begin
            v = wrapFix(vSum);
            u = wrapFix(uSum);
        end
    endfunction

    // whole pool for a number of steps, appends motoneuron events
    function automatic void stepModel(input int steps, input fixT rate, input fixT pps,
                                      input fixT gain);
        int vIa[`NEURON_COUNT];
        int uIa[`NEURON_COUNT];
        int vMn[`NEURON_COUNT];
        int uMn[`NEURON_COUNT];
        int iSyn[`NEURON_COUNT];
        int iaCur;
        int mnCur;
        int decayed;
        bit iaFire;
        bit mnFire;
        for (int c = 0; c < `NEURON_COUNT; c++) begin
            vIa[c]  = `V_REST;
            uIa[c]  = `V_REST >>> `B_SHIFT;
            vMn[c]  = `V_REST;
            uMn[c]  = `V_REST >>> `B_SHIFT;
            iSyn[c] = 0;
        end
        iaCur = wrapFix((longint'(rate) * longint'(pps)) >>> 16);
        for (int s = 0; s < steps; s++) begin
            for (int c = 0; c < `NEURON_COUNT; c++) begin
                izhStep(vIa[c], uIa[c], iaCur, iaFire);
                // synapse value from last step, less size offset
                mnCur = wrapFix((longint'(iSyn[c]) * longint'(gain)) >>> 16);
                mnCur = wrapFix(mnCur - c * `SIZE_STEP);
                izhStep(vMn[c], uMn[c], mnCur, mnFire);
                if (mnFire) begin
                    expSteps.push_back(stepT'(s));
                    expIdx.push_back(cellIdxT'(c));
                end
                decayed = wrapFix(iSyn[c] - (iSyn[c] >>> `SYN_TAU_SHIFT));
                iSyn[c] = iaFire ? wrapFix(decayed + `SYN_WEIGHT) : decayed;
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkStep(input string name, input stepT expected, input stepT actual);
        if (actual !== expected) begin
            $display("** Error %s: spike step expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "spike step mismatch");
        end
    endtask

    task automatic checkIndex(input string name, input cellIdxT expected,
                              input cellIdxT actual);
        if (actual !== expected) begin
            $display("** Error %s: spike index expected %0d, actual %0d", name, expected,
                     actual);
            $display("TEST FAILED");
            $fatal(1, "spike index mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor, credit responder, timeout
    //////////////////////////////////////////////////////////////////////

    // outputs sampled at posedge, values of the previous cycle
    always @(posedge rawclk) begin
        if (!rstN) begin
            issued   = 0;
            returned = 0;
        end else begin
            if (spikeValid) begin
                issued++;
                if (checking && expSteps.size() == 0) begin
                    $display("%s: spike event step %0d index %0d arrived, none was expected",
                             testName, spikeStep, spikeIndex);
                    $display("TEST FAILED");
                    $fatal(1, "extra output event");
                end else if (checking) begin
                    checkStep(testName, expSteps.pop_front(), spikeStep);
                    checkIndex(testName, expIdx.pop_front(), spikeIndex);
                end
            end
            if (creditReturn) begin
                returned++;
            end
            if (issued - returned > `CREDIT_INIT) begin
                $display("%s: %0d events sent against %0d credits returned",
                         testName, issued, returned);
                $display("TEST FAILED");
                $fatal(1, "credit overrun");
            end
        end
    end

    // 0..7 cycles normally, sometimes a long hold under back-pressure
    function automatic int pickDelay();
        int r;
        r = int'($random(seed) & 32'h7FFF_FFFF);
        if (backPressure && (r % 8 == 0)) begin
            return 40 + (r / 8) % 40;
        end
        return r % 8;
    endfunction

    // one credit back per received event, one at a time
    always @(posedge rawclk) begin
        if (!rstN) begin
            owed        = 0;
            returnDelay = -1;
            returnNext  = 1'b0;
        end else begin
            if (spikeValid) begin
                owed++;
            end
            returnNext = 1'b0;
            if (returnDelay < 0 && owed > 0) begin
                returnDelay = pickDelay();
            end
            if (returnDelay == 0) begin
                returnNext  = 1'b1;
                owed--;
                returnDelay = -1;
            end else if (returnDelay > 0) begin
                returnDelay--;
            end
        end
    end

    always @(negedge rawclk) begin
        creditReturn = returnNext;
    end

    always @(posedge rawclk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("run went past %0d cycles without finishing, events missing or stuck",
                     CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////////////////////////

    // reset, fresh model, release
    task automatic startRun(input string name, input int steps, input logic [15:0] h,
                            input fixT rate, input fixT pps, input fixT gain, input bit bp);
        @(negedge rawclk);
        checking     = 1'b0;
        rstN         = 1'b0;
        runEn        = 1'b0;
        halfCnt      = h;
        rateIa       = rate;
        ppsCoef      = pps;
        gainMn       = gain;
        backPressure = bp;
        testName     = name;
        expSteps.delete();
        expIdx.delete();
        stepModel(steps, rate, pps, gain);
        repeat (10) @(negedge rawclk);
        rstN     = 1'b1;
        runEn    = 1'b1;
        checking = 1'b1;
    endtask

    // step counter of the DUT scan
    task automatic waitForStep(input int steps);
        while (uut.sequencer.stepReg != stepT'(steps)) begin
            @(negedge rawclk);
        end
    endtask

    // stop the scan, drain the queue, catch stragglers
    task automatic finishRun(input int steps);
        waitForStep(steps);
        runEn = 1'b0;
        while (expSteps.size() != 0) begin
            @(negedge rawclk);
        end
        while (owed != 0 || returnDelay >= 0) begin
            @(negedge rawclk);
        end
        repeat (16) @(negedge rawclk);
    endtask

    initial begin
        rstN    = 1'b0;
        runEn   = 1'b0;
        halfCnt = 16'd0;
        rateIa  = '0;
        ppsCoef = '0;
        gainMn  = '0;

        // silent Ia, nothing may come out
        startRun("noIaDrive", RUN_STEPS, 16'd0, 18'sh00000, PPS_UNIT, GAIN_HIGH, 1'b0);
        finishRun(RUN_STEPS);

        startRun("constantDrive", RUN_STEPS, 16'd0, RATE_IA, PPS_UNIT, GAIN_HIGH, 1'b0);
        finishRun(RUN_STEPS);

        // offset keeps high indices quiet longer
        startRun("sizePrinciple", RUN_STEPS, 16'd0, RATE_IA, PPS_UNIT, GAIN_MOD, 1'b0);
        finishRun(RUN_STEPS);

        startRun("backPressure", RUN_STEPS, 16'd0, RATE_IA, PPS_UNIT, GAIN_HIGH, 1'b1);
        finishRun(RUN_STEPS);

        // slower ticks, same sequence
        startRun("slowTick", RUN_STEPS, 16'd3, RATE_IA, PPS_UNIT, GAIN_HIGH, 1'b0);
        finishRun(RUN_STEPS);

        // cut a run short, then start over from step 0
        startRun("midRunReset", RUN_STEPS, 16'd0, RATE_IA, PPS_UNIT, GAIN_MOD, 1'b0);
        waitForStep(PART_STEPS);
        startRun("afterReset", RUN_STEPS, 16'd0, RATE_IA, PPS_UNIT, GAIN_MOD, 1'b0);
        finishRun(RUN_STEPS);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/neuronPoolPkg.sv
design/neuronLinkIf.sv
design/neuronSequencer.sv
design/izhNeuronArray.sv
design/decaySynapseArray.sv
design/spikeEventQueue.sv
design/neuronPool.sv
bench/neuronPoolTb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= neuronPoolTb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
PASS_TEXT  := TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the output
sim: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
